/* rtl/adc_pkg.sv */
// Dual 8-bit converter with channels A and B
// Output coding is offset binary
//   8'h00 -> negative full scale
//   8'h80 -> mid scale
//   8'hFF -> positive full scale
// The DORA / DORB pins raise the overrange flag per channel

package adc_pkg;

    // Converter resolution
    localparam int unsigned ADC_BITS = 8;

    ////////////////////////////////////////
    // One channel, one conversion
    ////////////////////////////////////////

    typedef struct packed {
        logic [ADC_BITS-1:0] data;  // Offset binary code
        logic                ovr;   // Overrange, from DORx pin
    } adc_sample_t;

    ////////////////////////////////////////
    // Both channels, same sample clock
    ////////////////////////////////////////

    // A and B are converted on the same clk edge,
    // so they travel as one pair with one strobe
    typedef struct packed {
        adc_sample_t a;  // Channel A (DOA / DORA)
        adc_sample_t b;  // Channel B (DOB / DORB)
    } adc_pair_t;

endpackage

/* rtl/stream_pkg.sv */
// Everything downstream of the decimators lives here
// Output words match the FT601 32-bit data bus

package stream_pkg;

    // Signed window sum width
    // 64 samples of -128..127 give -8192..8128 and fit 15 bits
    localparam int unsigned RESULT_SUM_BITS = 15;

    ////////////////////////////////////////
    // Per-channel decimator result
    ////////////////////////////////////////

    // Exactly 16 bits for one half of a data word
    typedef struct packed {
        logic                               ovr;  // Sticky over the window
        logic signed [RESULT_SUM_BITS-1:0]  sum;  // Two's complement sum
    } chan_result_t;

    ////////////////////////////////////////
    // USB side
    ////////////////////////////////////////

    // One FT601 bus beat
    typedef logic [31:0] usb_word_t;

    // Upper half of a header word
    // Lower half carries the 16-bit frame number
    localparam logic [15:0] FRAME_MAGIC = 16'hA5C3;

    // Data word layout from the MSB down
    //   [31]    A ovr
    //   [30:16] A sum
    //   [15]    B ovr
    //   [14:0]  B sum

    ////////////////////////////////////////
    // Packer FSM
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        PK_IDLE   = 2'd0,  // Waiting for run
        PK_STREAM = 2'd1,  // Results go straight out
        PK_HEADER = 2'd2   // Header sent and data word next
    } pk_state_e;

endpackage

/* rtl/chan_decimator.sv */
`timescale 1ns/1ps

// One ADC channel into a decimated, signed sum
//
// Window is 2^DECIM_LOG2 accepted sample strobes.
// result_valid comes one cycle after the edge that
// takes the last sample of the window.

module chan_decimator #(
    parameter int unsigned DECIM_LOG2 = 2  // Window length log2, 1..6
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      run,           // Low holds everything cleared
    input  adc_pkg::adc_sample_t      sample,
    input  logic                      sample_valid,  // Single-cycle strobe
    output stream_pkg::chan_result_t  result,
    output logic                      result_valid   // Single-cycle strobe
);

    import adc_pkg::*;
    import stream_pkg::*;

    ////////////////////////////////////////
    // Sample conversion
    ////////////////////////////////////////

    logic signed [ADC_BITS-1:0]         sample_tc;   // Two's complement code
    logic signed [RESULT_SUM_BITS-1:0]  sample_ext;  // Sign-extended to sum width

    // Offset binary to two's complement is just the MSB flipped
    assign sample_tc  = {~sample.data[ADC_BITS-1], sample.data[ADC_BITS-2:0]};
    assign sample_ext = RESULT_SUM_BITS'(sample_tc);  // Signed cast, sign-extends

    ////////////////////////////////////////
    // Window control
    ////////////////////////////////////////

    logic [DECIM_LOG2-1:0]              cnt;       // Samples taken in this window
    logic signed [RESULT_SUM_BITS-1:0]  acc;       // Running sum, excludes current
    logic                               ovr_acc;   // Sticky ovr so far
    logic                               accept;    // Sample counted this cycle
    logic                               last;      // Final sample of window
    logic signed [RESULT_SUM_BITS-1:0]  sum_next;  // Sum including this sample

    assign accept   = run & sample_valid;
    assign last     = &cnt;                 // cnt == 2^DECIM_LOG2 - 1
    assign sum_next = acc + sample_ext;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt          <= '0;
            acc          <= '0;
            ovr_acc      <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;  // Strobe by default

            if (!run) begin
                // Stopped, drop any partial window
                cnt     <= '0;
                acc     <= '0;
                ovr_acc <= 1'b0;
            end else if (accept) begin
                cnt <= cnt + 1'b1;  // Wraps to 0 after last

                if (last) begin
                    // Window done, start fresh on next strobe
                    acc          <= '0;
                    ovr_acc      <= 1'b0;
                    result_valid <= 1'b1;
                end else begin
                    acc     <= sum_next;
                    ovr_acc <= ovr_acc | sample.ovr;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Result register
    ////////////////////////////////////////

    // Loaded only on the closing sample, held until next window
    always_ff @(posedge clk) begin
        if (accept && last) begin
            result.sum <= sum_next;
            result.ovr <= ovr_acc | sample.ovr;  // Include closing sample's flag
        end
    end

endmodule

/* rtl/frame_packer.sv */
`timescale 1ns/1ps

// Joins the A and B results into FT601 words
//
// A header word goes ahead of every FRAME_LEN data words.
// Data words leave one cycle after result_valid, or two
// when a header has to be squeezed in first.

module frame_packer #(
    parameter int unsigned FRAME_LEN = 8  // Data words per frame, 2..65535
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      run,
    input  stream_pkg::chan_result_t  result_a,
    input  stream_pkg::chan_result_t  result_b,
    input  logic                      result_valid,  // From channel A decimator
    output stream_pkg::usb_word_t     word,
    output logic                      word_valid     // No back-pressure
);

    import stream_pkg::*;

    localparam int unsigned     CNT_W    = $clog2(FRAME_LEN);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(FRAME_LEN - 1);

    ////////////////////////////////////////
    // State and counters
    ////////////////////////////////////////

    pk_state_e         state;
    logic [CNT_W-1:0]  word_cnt;   // Data words sent in current frame
    logic [15:0]       frame_num;  // Wraps at 16 bits
    chan_result_t      hold_a;     // Pair parked during header beat
    chan_result_t      hold_b;

    logic header_due;  // Next data word opens a frame
    logic frame_last;  // Next data word closes a frame
    logic hdr_out;     // Header word this edge
    logic data_out;    // Data word this edge
    logic use_hold;    // Data comes from parked pair

    assign header_due = (word_cnt == '0);
    assign frame_last = (word_cnt == LAST_CNT);

    // Half of a data word, ovr on top of the sum
    function automatic logic [15:0] to_half(input chan_result_t r);
        return {r.ovr, r.sum};
    endfunction

    ////////////////////////////////////////
    // Beat decode
    ////////////////////////////////////////

    always_comb begin
        hdr_out  = 1'b0;
        data_out = 1'b0;
        use_hold = 1'b0;

        if (run) begin
            case (state)
                PK_STREAM: begin
                    if (result_valid) begin
                        hdr_out  = header_due;
                        data_out = !header_due;
                    end
                end
                PK_HEADER: begin
                    data_out = 1'b1;  // Held pair, no new result possible here
                    use_hold = 1'b1;
                end
                default: ;  // Idle sends nothing
            endcase
        end
    end

    ////////////////////////////////////////
    // FSM and counters
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= PK_IDLE;
            word_cnt   <= '0;
            frame_num  <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= hdr_out | data_out;

            // Next state
            if (!run) begin
                state <= PK_IDLE;
            end else begin
                case (state)
                    PK_IDLE:   state <= PK_STREAM;
                    PK_STREAM: state <= hdr_out ? PK_HEADER : PK_STREAM;
                    PK_HEADER: state <= PK_STREAM;
                    default:   state <= PK_IDLE;
                endcase
            end

            // Frame bookkeeping
            if (state == PK_IDLE) begin
                word_cnt  <= '0;  // Fresh start on rising run
                frame_num <= '0;
            end else if (data_out) begin
                if (frame_last) begin
                    word_cnt  <= '0;
                    frame_num <= frame_num + 1'b1;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Output word
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (hdr_out) begin
            word   <= {FRAME_MAGIC, frame_num};
            hold_a <= result_a;  // Sent on the following beat
            hold_b <= result_b;
        end else if (data_out) begin
            if (use_hold) begin
                word <= {to_half(hold_a), to_half(hold_b)};
            end else begin
                word <= {to_half(result_a), to_half(result_b)};
            end
        end
    end

endmodule

/* rtl/r24bb_rx_top.sv */
`timescale 1ns/1ps

// r24bb receive path
// MAX19506 pair -> two decimators -> frame packer -> FT601 word stream

module r24bb_rx_top #(
    parameter int unsigned DECIM_LOG2 = 2,  // Window of 4 samples
    parameter int unsigned FRAME_LEN  = 8   // Data words per header
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   run,           // Start / stop streaming
    input  adc_pkg::adc_pair_t     sample,        // A and B together
    input  logic                   sample_valid,
    output stream_pkg::usb_word_t  word,          // FT601 data bus word
    output logic                   word_valid
);

    import stream_pkg::*;

    ////////////////////////////////////////
    // Decimators, one per channel
    ////////////////////////////////////////

    chan_result_t  result_a;
    chan_result_t  result_b;
    logic          result_valid;  // Channel A strobe, B is identical

    chan_decimator #(
        .DECIM_LOG2   (DECIM_LOG2)
    ) u_dec_a (
        .clk          (clk),
        .arst_n       (arst_n),
        .run          (run),
        .sample       (sample.a),
        .sample_valid (sample_valid),
        .result       (result_a),
        .result_valid (result_valid)
    );

    // Same strobes in, so its valid pulse matches A and is left open
    chan_decimator #(
        .DECIM_LOG2   (DECIM_LOG2)
    ) u_dec_b (
        .clk          (clk),
        .arst_n       (arst_n),
        .run          (run),
        .sample       (sample.b),
        .sample_valid (sample_valid),
        .result       (result_b),
        .result_valid ()
    );

    ////////////////////////////////////////
    // Packer
    ////////////////////////////////////////

    frame_packer #(
        .FRAME_LEN    (FRAME_LEN)
    ) u_packer (
        .clk          (clk),
        .arst_n       (arst_n),
        .run          (run),
        .result_a     (result_a),
        .result_b     (result_b),
        .result_valid (result_valid),
        .word         (word),
        .word_valid   (word_valid)
    );

endmodule

/* testbench/rx_checker.sv */
`timescale 1ns/1ps

// Watches the receive path ports, predicts every output word
// and compares the words in arrival order

module rx_checker #(
    parameter int DECIM_LOG2 = 2,
    parameter int FRAME_LEN  = 8
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   run,
    input  adc_pkg::adc_pair_t     sample,
    input  logic                   sample_valid,
    input  stream_pkg::usb_word_t  word,
    input  logic                   word_valid,
    input  logic                   timing_en,  // Check arrival cycle too
    input  logic                   end_test,   // Closing cycle of a test
    input  int                     test_num,
    output int                     pending,    // Words still expected
    output int                     errors,
    output int                     tests_ok,
    output int                     tests_bad
);

    import stream_pkg::*;

    localparam int          WIN       = 1 << DECIM_LOG2;
    localparam logic [15:0] HDR_MAGIC = 16'hA5C3;

    typedef struct packed {
        logic [31:0] value;
        int          due;    // Negedge count of arrival
    } expect_t;

    expect_t exp_q[$];
    int      cycle    = 0;
    int      q_size   = 0;
    int      err_cnt  = 0;
    int      err_base = 0;  // Errors before this test
    int      n_ok     = 0;
    int      n_bad    = 0;
    int      n_words  = 0;
    int      win_cnt  = 0;
    int      sum_a    = 0;
    int      sum_b    = 0;
    logic    ovr_a    = 1'b0;
    logic    ovr_b    = 1'b0;
    int      data_cnt = 0;  // Data words in current frame
    int      frame    = 0;

    assign pending   = q_size;
    assign errors    = err_cnt;
    assign tests_ok  = n_ok;
    assign tests_bad = n_bad;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Offset binary, 0x80 is zero
    function automatic int code_value(input logic [7:0] code);
        return int'(code) - 128;
    endfunction

    function automatic usb_word_t expected_word(input logic is_header, input int frame_no,
                                                input int sa, input logic oa,
                                                input int sb, input logic ob);
        logic [14:0] half_a;
        logic [14:0] half_b;
        half_a = 15'(sa);  // Two's complement, 15 bits
        half_b = 15'(sb);
        if (is_header) begin
            return {HDR_MAGIC, 16'(frame_no)};
        end else begin
            return {oa, half_a, ob, half_b};
        end
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1:       return "constant input";
            2:       return "random gaps";
            3:       return "sticky overrange";
            4:       return "framing";
            5:       return "run restart";
            default: return "unnamed";
        endcase
    endfunction

    task automatic push_expect(input usb_word_t value, input int due);
        expect_t e;
        e.value = value;
        e.due   = due;
        exp_q.push_back(e);
    endtask

    task automatic clear_model(input logic whole);
        win_cnt = 0;
        sum_a   = 0;
        sum_b   = 0;
        ovr_a   = 1'b0;
        ovr_b   = 1'b0;
        if (whole) begin
            data_cnt = 0;  // Next word opens frame 0
            frame    = 0;
        end
    endtask

    task automatic take_sample();
        sum_a   = sum_a + code_value(sample.a.data);
        sum_b   = sum_b + code_value(sample.b.data);
        ovr_a   = ovr_a | sample.a.ovr;
        ovr_b   = ovr_b | sample.b.ovr;
        win_cnt = win_cnt + 1;
        if (win_cnt == WIN) begin
            if (data_cnt == 0) begin
                // Header first, data one beat behind
                push_expect(expected_word(1'b1, frame, 0, 1'b0, 0, 1'b0), cycle + 2);
                push_expect(expected_word(1'b0, frame, sum_a, ovr_a, sum_b, ovr_b), cycle + 3);
            end else begin
                push_expect(expected_word(1'b0, frame, sum_a, ovr_a, sum_b, ovr_b), cycle + 2);
            end
            data_cnt = data_cnt + 1;
            if (data_cnt == FRAME_LEN) begin
                data_cnt = 0;
                frame    = (frame + 1) % 65536;  // 16-bit wrap
            end
            clear_model(1'b0);
        end
    endtask

    ////////////////////////////////////////
    // Comparison and test bookkeeping
    ////////////////////////////////////////

    task automatic compare_word();
        expect_t e;
        if (exp_q.size() == 0) begin
            $display("Word %h came out at time %0t while no word was expected", word, $time);
            err_cnt++;
        end else begin
            e = exp_q.pop_front();
            n_words++;
            if (word !== e.value) begin
                $display("CHECK FAILED at %0t: word %h, expected %h", $time, word, e.value);
                err_cnt++;
            end else if (timing_en && cycle != e.due) begin
                $display("CHECK FAILED at %0t: word %h in cycle %0d, expected cycle %0d",
                         $time, word, cycle, e.due);
                err_cnt++;
            end
        end
    endtask

    task automatic close_test();
        if (exp_q.size() != 0) begin
            $display("Test %0d ended with %0d expected words that never came out",
                     test_num, exp_q.size());
            err_cnt++;
            exp_q.delete();
        end
        if (err_cnt == err_base) begin
            n_ok++;
            $display("Test %0d %s: %0d words, ok", test_num, test_name(test_num), n_words);
        end else begin
            n_bad++;
            $display("Test %0d %s: %0d words, %0d errors", test_num, test_name(test_num),
                     n_words, err_cnt - err_base);
        end
        err_base = err_cnt;
        n_words  = 0;
    endtask

    // Negedge sampling, inputs and outputs both settled here
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (!arst_n) begin
            exp_q.delete();
            clear_model(1'b1);
        end else begin
            if (word_valid) begin
                compare_word();
            end
            if (!run) begin
                clear_model(1'b1);  // Partial window dropped
            end else if (sample_valid) begin
                take_sample();
            end
            if (end_test) begin
                close_test();
            end
        end
        q_size = exp_q.size();
    end

endmodule

/* testbench/tb_r24bb_rx.sv */
`timescale 1ns/1ps

module tb_r24bb_rx;

    import adc_pkg::*;
    import stream_pkg::*;

    localparam int unsigned DECIM_LOG2 = 2;
    localparam int unsigned FRAME_LEN  = 8;
    localparam int          WIN        = 1 << DECIM_LOG2;

    // Samples per test
    localparam int N_CONST   = 16 * WIN;
    localparam int N_RAND    = 32 * WIN;
    localparam int N_OVR     = 8 * WIN;
    localparam int N_FRAME   = 36 * WIN;      // Four frames and a bit
    localparam int N_PART    = WIN / 2;       // Cut-off window
    localparam int N_PRE     = (FRAME_LEN + 2) * WIN + N_PART;  // Into frame 1 before the cut
    localparam int N_POST    = 4 * WIN;
    localparam int N_RESTART = N_PRE + N_POST;
    localparam int OVR_IDX   = 2 * WIN + 1;   // Inside the third window
    localparam int N_TESTS   = 5;

    localparam int CYCLE_LIMIT  = 2 * (N_CONST + N_RAND + N_OVR + N_FRAME + N_RESTART) + 1000;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_MAX    = 16;
    localparam realtime DRIVE_DELAY = 0.5;

    logic       clk;
    logic       arst_n;
    logic       run;
    adc_pair_t  sample;
    logic       sample_valid;
    usb_word_t  word;
    logic       word_valid;
    logic       end_test;
    logic       timing_en;
    int         test_num;
    int         pending;
    int         errors;
    int         tests_ok;
    int         tests_bad;
    integer     seed;
    int         cycles = 0;

    always #2 clk = ~clk;  // 4 ns

    r24bb_rx_top #(
        .DECIM_LOG2 (DECIM_LOG2),
        .FRAME_LEN  (FRAME_LEN)
    ) u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .run          (run),
        .sample       (sample),
        .sample_valid (sample_valid),
        .word         (word),
        .word_valid   (word_valid)
    );

    rx_checker #(
        .DECIM_LOG2 (DECIM_LOG2),
        .FRAME_LEN  (FRAME_LEN)
    ) u_chk (
        .clk          (clk),
        .arst_n       (arst_n),
        .run          (run),
        .sample       (sample),
        .sample_valid (sample_valid),
        .word         (word),
        .word_valid   (word_valid),
        .timing_en    (timing_en),
        .end_test     (end_test),
        .test_num     (test_num),
        .pending      (pending),
        .errors       (errors),
        .tests_ok     (tests_ok),
        .tests_bad    (tests_bad)
    );

    // Hard stop
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout, the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    function automatic adc_pair_t make_pair(input logic [7:0] a, input logic oa,
                                            input logic [7:0] b, input logic ob);
        adc_pair_t p;
        p.a.data = a;
        p.a.ovr  = oa;
        p.b.data = b;
        p.b.ovr  = ob;
        return p;
    endfunction

    // Random codes with overrange about one in 32
    function automatic adc_pair_t random_pair(input logic [31:0] r);
        return make_pair(r[7:0], r[20:16] == 5'd0, r[15:8], r[25:21] == 5'd0);
    endfunction

    task automatic drive(input logic v, input adc_pair_t s);
        @(posedge clk);
        #DRIVE_DELAY;
        sample_valid = v;
        sample       = s;
    endtask

    task automatic idle(input int n);
        repeat (n) drive(1'b0, sample);
    endtask

    task automatic set_run(input logic r);
        @(posedge clk);
        #DRIVE_DELAY;
        run          = r;
        sample_valid = 1'b0;
    endtask

    task automatic start_test(input int n, input logic timed);
        test_num  = n;
        timing_en = timed;
        set_run(1'b1);
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        idle(1);
        while (pending != 0 && waited < DRAIN_MAX) begin
            idle(1);  // Packer still busy
            waited++;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        end_test = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        end_test = 1'b0;
        run      = 1'b0;
        idle(2);
    endtask

    task automatic send_random(input int n);
        logic [31:0] r;
        repeat (n) begin
            r = $random(seed);
            drive(1'b1, random_pair(r));
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_random_gaps();
        logic [31:0] r;
        start_test(2, 1'b0);
        for (int i = 0; i < N_RAND; i++) begin
            r = $random(seed);
            if (r[31:29] < 3'd2) begin
                idle(int'(r[28:27]) + 1);  // Strobe held low a while
            end
            drive(1'b1, random_pair(r));
        end
        finish_test();
    endtask

    initial begin
        seed         = 32'hda67_b07f;
        clk          = 1'b0;
        arst_n       = 1'b0;
        run          = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        end_test     = 1'b0;
        timing_en    = 1'b0;
        test_num     = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        idle(2);

        start_test(1, 1'b1);
        repeat (N_CONST) drive(1'b1, make_pair(8'hC5, 1'b0, 8'h3A, 1'b0));
        finish_test();

        test_random_gaps();

        start_test(3, 1'b1);
        for (int i = 0; i < N_OVR; i++) begin
            drive(1'b1, make_pair(8'(8'h70 + i), 1'b0, 8'(8'h90 - i), i == OVR_IDX));
        end
        finish_test();

        start_test(4, 1'b1);
        send_random(N_FRAME);
        finish_test();

        start_test(5, 1'b1);
        send_random(N_PRE);
        idle(6);            // Last full window out with a partial one open
        set_run(1'b0);
        idle(3);
        set_run(1'b1);
        send_random(N_POST);
        finish_test();

        $display("Summary: %0d tests ok, %0d tests failed, %0d errors",
                 tests_ok, tests_bad, errors);
        if (tests_ok == N_TESTS && tests_bad == 0 && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* r24bb_rx.f */
rtl/adc_pkg.sv
rtl/stream_pkg.sv
rtl/chan_decimator.sv
rtl/frame_packer.sv
rtl/r24bb_rx_top.sv
testbench/rx_checker.sv
testbench/tb_r24bb_rx.sv

/* Makefile */
# Verilator build and run for the r24bb receive path

VERILATOR  ?= verilator
TOP        ?= tb_r24bb_rx
RTL_TOP    ?= r24bb_rx_top
FILELIST   ?= r24bb_rx.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= -Wall
PASS_TEXT  ?= TESTS PASSED

RTL_SRCS := $(shell grep '^rtl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Fails unless the pass message shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
